// ==== hw/lsu_fwd_pkg.sv ====
package lsu_fwd_pkg;

   //************************************************************************
   // memory operation encodings
   //************************************************************************

   // kind of operation entering dc1
   typedef enum logic [1:0] {
      op_none  = 2'd0,
      op_load  = 2'd1,
      op_store = 2'd2
   } lsu_op_e;

   // access size
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } ldst_size_e;

   //************************************************************************
   // datapath geometry
   //************************************************************************

   localparam int NUM_LANES  = 4;   // byte lanes per word
   localparam int DATA_WIDTH = 32;  // one word

endpackage

// ==== hw/lsu_fwd_decode.sv ====
`timescale 1ns/1ps

module lsu_fwd_decode #(
   parameter int  ADDR_WIDTH = 32,
   localparam int WORD_W     = ADDR_WIDTH - 2,      // word index bits
   localparam int OFF_W      = ADDR_WIDTH - WORD_W  // byte offset below the word index
) (
   input  logic                                  clk,
   input  logic                                  reset,

   input  lsu_fwd_pkg::lsu_op_e                  op_dc1,
   input  lsu_fwd_pkg::ldst_size_e               size_dc1,
   input  logic [ADDR_WIDTH-1:0]                 addr_dc1,
   input  logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    store_data_dc1,
   input  logic                                  side_effect_dc1,

   output logic                                  load_dc2,
   output logic                                  store_dc2,
   output logic [WORD_W-1:0]                     lo_word_dc2,     // word of the first byte
   output logic [WORD_W-1:0]                     hi_word_dc2,     // next word for crossing accesses
   output logic [lsu_fwd_pkg::NUM_LANES-1:0]     byteen_lo_dc2,
   output logic [lsu_fwd_pkg::NUM_LANES-1:0]     byteen_hi_dc2,
   output logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    store_lo_dc2,
   output logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    store_hi_dc2,
   output logic                                  side_effect_dc2,
   output logic [OFF_W-1:0]                      addr_off_dc2
);

   import lsu_fwd_pkg::*;

   ldst_size_e                  size_dc2;
   logic [ADDR_WIDTH-1:0]       addr_dc2;
   logic [DATA_WIDTH-1:0]       store_data_dc2;

   logic [NUM_LANES-1:0]        byteen_dc2;       // enables relative to the start byte
   logic [2*NUM_LANES-1:0]      byteen_ext_dc2;   // 8 byte window over lo and hi word
   logic [2*DATA_WIDTH-1:0]     store_ext_dc2;

   //************************************************************************
   // dc1 -> dc2 stage register
   //************************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         load_dc2  <= 1'b0;
         store_dc2 <= 1'b0;
      end else begin
         load_dc2  <= (op_dc1 == op_load);
         store_dc2 <= (op_dc1 == op_store);
      end
   end

   // dc2 payload
   always_ff @(posedge clk) begin
      size_dc2        <= size_dc1;
      addr_dc2        <= addr_dc1;
      store_data_dc2  <= store_data_dc1;
      side_effect_dc2 <= side_effect_dc1;
   end

   //************************************************************************
   // expansion into the lo/hi word window
   //************************************************************************

   always_comb begin
      case (size_dc2)
         size_byte: byteen_dc2 = NUM_LANES'(1);
         size_half: byteen_dc2 = NUM_LANES'(3);
         default:   byteen_dc2 = '1;              // word
      endcase
   end

   assign addr_off_dc2   = addr_dc2[OFF_W-1:0];
   assign lo_word_dc2    = addr_dc2[ADDR_WIDTH-1:OFF_W];
   assign hi_word_dc2    = lo_word_dc2 + WORD_W'(1);

   assign byteen_ext_dc2 = {{NUM_LANES{1'b0}}, byteen_dc2} << addr_off_dc2;
   assign store_ext_dc2  = {{DATA_WIDTH{1'b0}}, store_data_dc2} << {addr_off_dc2, 3'b000};

   assign byteen_lo_dc2  = byteen_ext_dc2[NUM_LANES-1:0];
   assign byteen_hi_dc2  = byteen_ext_dc2[2*NUM_LANES-1:NUM_LANES];
   assign store_lo_dc2   = store_ext_dc2[DATA_WIDTH-1:0];
   assign store_hi_dc2   = store_ext_dc2[2*DATA_WIDTH-1:DATA_WIDTH];

endmodule

// ==== hw/lsu_fwd_execute.sv ====
`timescale 1ns/1ps

module lsu_fwd_execute #(
   parameter int  ADDR_WIDTH = 32,
   localparam int WORD_W     = ADDR_WIDTH - 2
) (
   input  logic                                  clk,
   input  logic                                  reset,

   // dc2 operation
   input  logic                                  load_dc2,
   input  logic                                  store_dc2,
   input  logic [WORD_W-1:0]                     lo_word_dc2,
   input  logic [WORD_W-1:0]                     hi_word_dc2,
   input  logic [lsu_fwd_pkg::NUM_LANES-1:0]     byteen_lo_dc2,
   input  logic [lsu_fwd_pkg::NUM_LANES-1:0]     byteen_hi_dc2,
   input  logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    store_lo_dc2,
   input  logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    store_hi_dc2,

   // per lane hits and data for the dc2 load
   output logic [lsu_fwd_pkg::NUM_LANES-1:0]     byte_hit_lo,
   output logic [lsu_fwd_pkg::NUM_LANES-1:0]     byte_hit_hi,
   output logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    fwd_lo,
   output logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    fwd_hi
);

   import lsu_fwd_pkg::*;

   localparam int DEPTH = 3;   // dc3, dc4, dc5

   // store pipe with the youngest store (dc3) at index 0
   // second index selects the lo (0) or hi (1) word of the store
   logic [DEPTH-1:0]            st_valid;
   logic [WORD_W-1:0]           st_word   [DEPTH][2];
   logic [NUM_LANES-1:0]        st_byteen [DEPTH][2];
   logic [DATA_WIDTH-1:0]       st_data   [DEPTH][2];

   // dc2 load words with the lo word at index 0
   logic [WORD_W-1:0]           ld_word   [2];
   logic [NUM_LANES-1:0]        ld_byteen [2];

   logic [NUM_LANES-1:0]        stage_hit  [DEPTH][2];   // [stage][load word]
   logic [DATA_WIDTH-1:0]       stage_data [DEPTH][2];
   logic [NUM_LANES-1:0]        byte_hit   [2];
   logic [DATA_WIDTH-1:0]       fwd        [2];

   assign ld_word[0]   = lo_word_dc2;
   assign ld_word[1]   = hi_word_dc2;
   assign ld_byteen[0] = byteen_lo_dc2;
   assign ld_byteen[1] = byteen_hi_dc2;

   //************************************************************************
   // dc3..dc5 store pipe
   //************************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         st_valid <= '0;
      end else begin
         st_valid <= {st_valid[DEPTH-2:0], store_dc2};   // every stage moves each cycle
      end
   end

   always_ff @(posedge clk) begin
      st_word[0][0]   <= lo_word_dc2;
      st_word[0][1]   <= hi_word_dc2;
      st_byteen[0][0] <= byteen_lo_dc2;
      st_byteen[0][1] <= byteen_hi_dc2;
      st_data[0][0]   <= store_lo_dc2;
      st_data[0][1]   <= store_hi_dc2;
      for (int s = 1; s < DEPTH; s++) begin
         for (int w = 0; w < 2; w++) begin
            st_word[s][w]   <= st_word[s-1][w];
            st_byteen[s][w] <= st_byteen[s-1][w];
            st_data[s][w]   <= st_data[s-1][w];
         end
      end
   end

   //************************************************************************
   // per stage hit detection
   //************************************************************************

   // a store's lo and hi words differ, so at most one of them matches a load word
   always_comb begin
      for (int s = 0; s < DEPTH; s++) begin
         for (int lw = 0; lw < 2; lw++) begin
            stage_hit[s][lw]  = '0;
            stage_data[s][lw] = '0;
            for (int sw = 0; sw < 2; sw++) begin
               if (load_dc2 && st_valid[s] && (ld_word[lw] == st_word[s][sw])) begin
                  stage_hit[s][lw]  = st_byteen[s][sw] & ld_byteen[lw];
                  stage_data[s][lw] = st_data[s][sw];
               end
            end
         end
      end
   end

   // walk from dc5 up to dc3 so the youngest hitting store wins each lane
   always_comb begin
      for (int lw = 0; lw < 2; lw++) begin
         byte_hit[lw] = '0;
         fwd[lw]      = '0;
         for (int i = 0; i < NUM_LANES; i++) begin
            for (int s = DEPTH-1; s >= 0; s--) begin
               if (stage_hit[s][lw][i]) begin
                  byte_hit[lw][i]   = 1'b1;
                  fwd[lw][8*i +: 8] = stage_data[s][lw][8*i +: 8];
               end
            end
         end
      end
   end

   assign byte_hit_lo = byte_hit[0];
   assign byte_hit_hi = byte_hit[1];
   assign fwd_lo      = fwd[0];
   assign fwd_hi      = fwd[1];

endmodule

// ==== hw/lsu_fwd_result.sv ====
`timescale 1ns/1ps

module lsu_fwd_result #(
   parameter int  ADDR_WIDTH = 32,
   localparam int WORD_W     = ADDR_WIDTH - 2,
   localparam int OFF_W      = ADDR_WIDTH - WORD_W
) (
   input  logic                                  clk,
   input  logic                                  reset,

   input  logic                                  load_dc2,
   input  logic [lsu_fwd_pkg::NUM_LANES-1:0]     byteen_lo_dc2,
   input  logic [lsu_fwd_pkg::NUM_LANES-1:0]     byteen_hi_dc2,
   input  logic                                  side_effect_dc2,
   input  logic [OFF_W-1:0]                      addr_off_dc2,
   input  logic [lsu_fwd_pkg::NUM_LANES-1:0]     byte_hit_lo,
   input  logic [lsu_fwd_pkg::NUM_LANES-1:0]     byte_hit_hi,
   input  logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    fwd_lo,
   input  logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    fwd_hi,
   input  logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    ld_bus_data_dc3,  // belongs to the dc3 load

   output logic                                  ld_valid_dc3,
   output logic                                  ld_hit_dc3,
   output logic                                  ld_full_hit_dc3,
   output logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    bus_read_data_dc3
);

   import lsu_fwd_pkg::*;

   logic                    full_hit_lo_dc2, full_hit_hi_dc2;
   logic                    hit_dc2, full_hit_dc2;
   logic [DATA_WIDTH-1:0]   fwd_data_dc2, fwd_data_dc3;

   // lanes the load does not touch count as covered
   assign full_hit_lo_dc2 = &(byte_hit_lo | ~byteen_lo_dc2);
   assign full_hit_hi_dc2 = &(byte_hit_hi | ~byteen_hi_dc2);

   assign hit_dc2      = load_dc2 & (|{byte_hit_hi, byte_hit_lo});
   assign full_hit_dc2 = full_hit_lo_dc2 & full_hit_hi_dc2 & load_dc2 & ~side_effect_dc2;

   // bring the start byte down to lane 0
   assign fwd_data_dc2 = DATA_WIDTH'({fwd_hi, fwd_lo} >> {addr_off_dc2, 3'b000});

   //************************************************************************
   // dc2 -> dc3 load register
   //************************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         ld_valid_dc3    <= 1'b0;
         ld_hit_dc3      <= 1'b0;
         ld_full_hit_dc3 <= 1'b0;
      end else begin
         ld_valid_dc3    <= load_dc2;
         ld_hit_dc3      <= hit_dc2;
         ld_full_hit_dc3 <= full_hit_dc2;
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_dc3 <= fwd_data_dc2;
   end

   assign bus_read_data_dc3 = ld_full_hit_dc3 ? fwd_data_dc3 : ld_bus_data_dc3;

endmodule

// ==== hw/lsu_fwd_top.sv ====
`timescale 1ns/1ps

module lsu_fwd_top #(
   parameter int  ADDR_WIDTH = 32,
   localparam int WORD_W     = ADDR_WIDTH - 2,
   localparam int OFF_W      = ADDR_WIDTH - WORD_W
) (
   input  logic                                  clk,
   input  logic                                  reset,

   // dc1 operation
   input  lsu_fwd_pkg::lsu_op_e                  op_dc1,
   input  lsu_fwd_pkg::ldst_size_e               size_dc1,
   input  logic [ADDR_WIDTH-1:0]                 addr_dc1,
   input  logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    store_data_dc1,
   input  logic                                  side_effect_dc1,

   input  logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    ld_bus_data_dc3,

   // dc3 load result
   output logic                                  ld_valid_dc3,
   output logic                                  ld_hit_dc3,
   output logic                                  ld_full_hit_dc3,
   output logic [lsu_fwd_pkg::DATA_WIDTH-1:0]    bus_read_data_dc3
);

   import lsu_fwd_pkg::*;

   logic                    load_dc2, store_dc2, side_effect_dc2;
   logic [WORD_W-1:0]       lo_word_dc2, hi_word_dc2;
   logic [NUM_LANES-1:0]    byteen_lo_dc2, byteen_hi_dc2;
   logic [DATA_WIDTH-1:0]   store_lo_dc2, store_hi_dc2;
   logic [OFF_W-1:0]        addr_off_dc2;

   logic [NUM_LANES-1:0]    byte_hit_lo, byte_hit_hi;
   logic [DATA_WIDTH-1:0]   fwd_lo, fwd_hi;

   lsu_fwd_decode #(.ADDR_WIDTH(ADDR_WIDTH)) decode0 (
      .clk             (clk),
      .reset           (reset),
      .op_dc1          (op_dc1),
      .size_dc1        (size_dc1),
      .addr_dc1        (addr_dc1),
      .store_data_dc1  (store_data_dc1),
      .side_effect_dc1 (side_effect_dc1),
      .load_dc2        (load_dc2),
      .store_dc2       (store_dc2),
      .lo_word_dc2     (lo_word_dc2),
      .hi_word_dc2     (hi_word_dc2),
      .byteen_lo_dc2   (byteen_lo_dc2),
      .byteen_hi_dc2   (byteen_hi_dc2),
      .store_lo_dc2    (store_lo_dc2),
      .store_hi_dc2    (store_hi_dc2),
      .side_effect_dc2 (side_effect_dc2),
      .addr_off_dc2    (addr_off_dc2)
   );

   lsu_fwd_execute #(.ADDR_WIDTH(ADDR_WIDTH)) execute0 (
      .clk             (clk),
      .reset           (reset),
      .load_dc2        (load_dc2),
      .store_dc2       (store_dc2),
      .lo_word_dc2     (lo_word_dc2),
      .hi_word_dc2     (hi_word_dc2),
      .byteen_lo_dc2   (byteen_lo_dc2),
      .byteen_hi_dc2   (byteen_hi_dc2),
      .store_lo_dc2    (store_lo_dc2),
      .store_hi_dc2    (store_hi_dc2),
      .byte_hit_lo     (byte_hit_lo),
      .byte_hit_hi     (byte_hit_hi),
      .fwd_lo          (fwd_lo),
      .fwd_hi          (fwd_hi)
   );

   lsu_fwd_result #(.ADDR_WIDTH(ADDR_WIDTH)) result0 (
      .clk               (clk),
      .reset             (reset),
      .load_dc2          (load_dc2),
      .byteen_lo_dc2     (byteen_lo_dc2),
      .byteen_hi_dc2     (byteen_hi_dc2),
      .side_effect_dc2   (side_effect_dc2),
      .addr_off_dc2      (addr_off_dc2),
      .byte_hit_lo       (byte_hit_lo),
      .byte_hit_hi       (byte_hit_hi),
      .fwd_lo            (fwd_lo),
      .fwd_hi            (fwd_hi),
      .ld_bus_data_dc3   (ld_bus_data_dc3),
      .ld_valid_dc3      (ld_valid_dc3),
      .ld_hit_dc3        (ld_hit_dc3),
      .ld_full_hit_dc3   (ld_full_hit_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3)
   );

endmodule

// ==== tests/lsu_fwd_tb.sv ====
`timescale 1ns/1ps

module lsu_fwd_tb;

   import lsu_fwd_pkg::*;

   localparam logic [31:0] SEED           = 32'h1e89;
   localparam int          NUM_RANDOM_OPS = 400;
   localparam int          ADDR_SPAN      = 16;     // small window keeps hits frequent
   localparam int          DIRECTED_OPS   = 120;
   localparam int          WATCHDOG_NS    = (NUM_RANDOM_OPS + DIRECTED_OPS) * 4 + 400;
   localparam logic [31:0] BUS_MIX        = 32'hc3a55a3c;

   logic        clk = 1'b0;
   logic        reset;
   lsu_op_e     op_dc1;
   ldst_size_e  size_dc1;
   logic [31:0] addr_dc1;
   logic [31:0] store_data_dc1;
   logic        side_effect_dc1;
   logic [31:0] ld_bus_data_dc3 = BUS_MIX;          // pattern of address 0
   logic        ld_valid_dc3, ld_hit_dc3, ld_full_hit_dc3;
   logic [31:0] bus_read_data_dc3;

   // expected results travel with the operation from dc1 to dc3
   logic        exp_load_dc1 = 1'b0, exp_load_dc2 = 1'b0, exp_load_dc3 = 1'b0;
   logic        exp_hit_dc1 = 1'b0, exp_hit_dc2 = 1'b0, exp_hit_dc3 = 1'b0;
   logic        exp_full_dc1 = 1'b0, exp_full_dc2 = 1'b0, exp_full_dc3 = 1'b0;
   logic [31:0] exp_data_dc1 = BUS_MIX, exp_data_dc2 = BUS_MIX, exp_data_dc3 = BUS_MIX;
   int          exp_test_dc1 = 0, exp_test_dc2 = 0, exp_test_dc3 = 0;
   logic [31:0] bus_addr_dc2 = '0;

   // last three issued operations with the youngest at index 0
   lsu_op_e     hist_op   [3];
   logic [31:0] hist_addr [3];
   int          hist_len  [3];
   logic [31:0] hist_data [3];

   string test_names [6] = '{"reset_idle", "store_load", "youngest_store",
                             "cross_word", "side_effect_age", "random_mix"};
   int    test_checks [6] = '{default: 0};
   int    test_errs   [6] = '{default: 0};
   int    total_checks = 0;
   int    total_errs   = 0;
   int    current_test = 0;

   lsu_fwd_top #(.ADDR_WIDTH(32)) dut0 (
      .clk               (clk),
      .reset             (reset),
      .op_dc1            (op_dc1),
      .size_dc1          (size_dc1),
      .addr_dc1          (addr_dc1),
      .store_data_dc1    (store_data_dc1),
      .side_effect_dc1   (side_effect_dc1),
      .ld_bus_data_dc3   (ld_bus_data_dc3),
      .ld_valid_dc3      (ld_valid_dc3),
      .ld_hit_dc3        (ld_hit_dc3),
      .ld_full_hit_dc3   (ld_full_hit_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3)
   );

   always #2 clk = ~clk;   // 4 ns period

   //************************************************************************
   // reference model
   //************************************************************************

   function automatic logic [31:0] bus_pattern(input logic [31:0] a);
      return (a * 32'h9e3779b1) ^ BUS_MIX;
   endfunction

   function automatic int size_bytes(input ldst_size_e sz);
      case (sz)
         size_byte: return 1;
         size_half: return 2;
         default:   return 4;
      endcase
   endfunction

   // youngest covering store supplies each byte of the load
   function automatic void ref_load(input logic [31:0] a, input int nbytes, input logic se,
                                    input lsu_op_e h_op [3], input logic [31:0] h_addr [3],
                                    input int h_len [3], input logic [31:0] h_data [3],
                                    output logic hit, output logic full,
                                    output logic [31:0] data);
      logic [31:0] b;
      logic        covered;
      hit  = 1'b0;
      full = 1'b1;
      data = '0;
      for (int i = 0; i < nbytes; i++) begin
         b       = a + 32'(i);
         covered = 1'b0;
         for (int k = 2; k >= 0; k--) begin   // oldest first so a younger store overwrites
            if (h_op[k] == op_store && b >= h_addr[k] && b < h_addr[k] + 32'(h_len[k])) begin
               covered         = 1'b1;
               data[8*i +: 8]  = 8'(h_data[k] >> (8 * (b - h_addr[k])));
            end
         end
         hit  = hit | covered;
         full = full & covered;
      end
      full = full & ~se;   // side-effect loads never count as full hits
   endfunction

   //************************************************************************
   // stimulus
   //************************************************************************

   task automatic issue(input lsu_op_e op, input ldst_size_e sz, input logic [31:0] a,
                        input logic [31:0] d, input logic se);
      logic        hit;
      logic        full;
      logic [31:0] fdata;
      hit   = 1'b0;
      full  = 1'b0;
      fdata = bus_pattern(a);
      if (op == op_load) begin
         ref_load(a, size_bytes(sz), se, hist_op, hist_addr, hist_len, hist_data,
                  hit, full, fdata);
         if (!full) fdata = bus_pattern(a);
      end
      @(posedge clk);
      op_dc1          <= op;
      size_dc1        <= sz;
      addr_dc1        <= a;
      store_data_dc1  <= d;
      side_effect_dc1 <= se;
      exp_load_dc1    <= (op == op_load);
      exp_hit_dc1     <= hit;
      exp_full_dc1    <= full;
      exp_data_dc1    <= fdata;
      exp_test_dc1    <= current_test;
      for (int k = 2; k > 0; k--) begin
         hist_op[k]   = hist_op[k-1];
         hist_addr[k] = hist_addr[k-1];
         hist_len[k]  = hist_len[k-1];
         hist_data[k] = hist_data[k-1];
      end
      hist_op[0]   = op;
      hist_addr[0] = a;
      hist_len[0]  = size_bytes(sz);
      hist_data[0] = d;
   endtask

   task automatic idle();
      issue(op_none, size_byte, 32'h0, 32'h0, 1'b0);
   endtask

   // drain the pipe and report the test
   task automatic finish_test();
      repeat (3) idle();
      repeat (3) @(negedge clk);
      @(posedge clk);
      $display("test %-16s %0d checks, %0d errors", test_names[current_test],
               test_checks[current_test], test_errs[current_test]);
   endtask

   task automatic run_random_mix();
      int          pick;
      lsu_op_e     op;
      ldst_size_e  sz;
      for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
         pick = $urandom_range(9, 0);
         op   = (pick < 4) ? op_load : (pick < 8) ? op_store : op_none;
         pick = $urandom_range(2, 0);
         sz   = (pick == 0) ? size_byte : (pick == 1) ? size_half : size_word;
         issue(op, sz, $urandom_range(ADDR_SPAN - 1, 0), $urandom(),
               ($urandom_range(7, 0) == 0));
      end
   endtask

   // bus data follows the address of the op entering dc3
   always @(posedge clk) begin
      exp_load_dc2    <= exp_load_dc1;
      exp_hit_dc2     <= exp_hit_dc1;
      exp_full_dc2    <= exp_full_dc1;
      exp_data_dc2    <= exp_data_dc1;
      exp_test_dc2    <= exp_test_dc1;
      exp_load_dc3    <= exp_load_dc2;
      exp_hit_dc3     <= exp_hit_dc2;
      exp_full_dc3    <= exp_full_dc2;
      exp_data_dc3    <= exp_data_dc2;
      exp_test_dc3    <= exp_test_dc2;
      bus_addr_dc2    <= addr_dc1;
      ld_bus_data_dc3 <= bus_pattern(bus_addr_dc2);
   end

   //************************************************************************
   // comparison at mid cycle where the dc3 outputs are settled
   //************************************************************************

   task automatic report_mismatch(input int id, input string field,
                                  input logic [31:0] expv, input logic [31:0] actv);
      $display("[ERROR] %s: %s expected %h actual %h", test_names[id], field, expv, actv);
      test_errs[id]++;
      total_errs++;
   endtask

   always @(negedge clk) begin
      if (!reset) begin
         test_checks[exp_test_dc3]++;
         total_checks++;
         if (ld_valid_dc3 !== exp_load_dc3)
            report_mismatch(exp_test_dc3, "ld_valid_dc3", 32'(exp_load_dc3), 32'(ld_valid_dc3));
         if (ld_hit_dc3 !== exp_hit_dc3)
            report_mismatch(exp_test_dc3, "ld_hit_dc3", 32'(exp_hit_dc3), 32'(ld_hit_dc3));
         if (ld_full_hit_dc3 !== exp_full_dc3)
            report_mismatch(exp_test_dc3, "ld_full_hit_dc3", 32'(exp_full_dc3),
                            32'(ld_full_hit_dc3));
         if (bus_read_data_dc3 !== exp_data_dc3)
            report_mismatch(exp_test_dc3, "bus_read_data_dc3", exp_data_dc3, bus_read_data_dc3);
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before all tests finished");
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      reset           = 1'b1;
      op_dc1          = op_none;
      size_dc1        = size_byte;
      addr_dc1        = '0;
      store_data_dc1  = '0;
      side_effect_dc1 = 1'b0;
      for (int k = 0; k < 3; k++) begin
         hist_op[k]   = op_none;
         hist_addr[k] = '0;
         hist_len[k]  = 1;
         hist_data[k] = '0;
      end
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      current_test = 0;                                        // nothing issued
      repeat (4) idle();
      finish_test();

      current_test = 1;
      issue(op_store, size_word, 32'h4, 32'ha1b2c3d4, 1'b0);
      issue(op_load,  size_word, 32'h4, 32'h0, 1'b0);
      finish_test();

      current_test = 2;
      issue(op_store, size_word, 32'h8, 32'h11223344, 1'b0);
      issue(op_store, size_word, 32'h8, 32'h55667788, 1'b0);  // younger one wins
      issue(op_load,  size_byte, 32'h9, 32'h0, 1'b0);
      finish_test();

      current_test = 3;
      issue(op_store, size_half, 32'h6, 32'h0000cafe, 1'b0);
      issue(op_store, size_half, 32'h8, 32'h0000f00d, 1'b0);
      issue(op_load,  size_word, 32'h6, 32'h0, 1'b0);         // merged across words
      issue(op_store, size_byte, 32'he, 32'h0000005a, 1'b0);
      issue(op_load,  size_word, 32'hd, 32'h0, 1'b0);         // only partly covered
      finish_test();

      current_test = 4;
      issue(op_store, size_word, 32'hc, 32'h0badf00d, 1'b0);
      issue(op_load,  size_word, 32'hc, 32'h0, 1'b1);
      issue(op_store, size_word, 32'h4, 32'h12345678, 1'b0);
      repeat (3) idle();                                       // store now past dc5
      issue(op_load,  size_word, 32'h4, 32'h0, 1'b0);
      finish_test();

      current_test = 5;
      run_random_mix();
      finish_test();

      $display("total %0d checks, %0d errors", total_checks, total_errs);
      if (total_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
hw/lsu_fwd_pkg.sv
hw/lsu_fwd_decode.sv
hw/lsu_fwd_execute.sv
hw/lsu_fwd_result.sv
hw/lsu_fwd_top.sv
tests/lsu_fwd_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module lsu_fwd_tb -f verilog.f -o lsu_fwd_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/lsu_fwd_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
   exit 0
fi
exit 1
